// File: u2_types_pkg.sv
////////////////////
// u2 control bus types
// Widths of the APB, settings and timing paths
////////////////////
`default_nettype none

package u2_types_pkg;

   typedef logic [31:0] word_t;       // APB and settings data
   typedef logic [7:0]  set_addr_t;   // settings register number
   typedef logic [3:0]  rb_sel_t;     // readback word index
   typedef logic [63:0] vita_time_t;  // ticks of dsp_clk
   typedef logic [11:0] apb_addr_t;   // byte address

   ////////////////////
   // Settings bus, one write per strobe
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      word_t     data;
   } set_bus_t;   // 41 bits

endpackage

`default_nettype wire

// File: u2_regs_pkg.sv
////////////////////
// u2 control register map
// Settings addresses, readback indices and reset values
////////////////////
`default_nettype none

package u2_regs_pkg;

   ////////////////////
   // Settings bus bases
   localparam int unsigned SR_MISC   = 0;    // 7 slots
   localparam int unsigned SR_TIME64 = 10;   // 2 slots

   // Offsets inside the misc bank
   localparam int unsigned MISC_CLOCK   = 0;
   localparam int unsigned MISC_SERDES  = 1;
   localparam int unsigned MISC_ADC     = 2;
   localparam int unsigned MISC_LED_SW  = 3;
   localparam int unsigned MISC_PHY     = 4;
   localparam int unsigned MISC_LED_SRC = 6;   // slot 5 was the bootloader flag

   // The low word commits the time load
   localparam int unsigned TIME_HI = 0;
   localparam int unsigned TIME_LO = 1;

   ////////////////////
   // Readback word table
   localparam logic [3:0] RB_SPI     = 4'd0;   // reserved slot
   localparam logic [3:0] RB_TIME_HI = 4'd10;
   localparam logic [3:0] RB_TIME_LO = 4'd11;
   localparam logic [3:0] RB_COMPAT  = 4'd12;
   localparam logic [3:0] RB_STATUS  = 4'd13;

   // Bump when the register map changes
   localparam logic [31:0] COMPAT_NUM    = {16'd10, 16'd0};   // major, minor
   localparam logic [31:0] RB_UNUSED     = 32'hffff_ffff;
   localparam logic [7:0]  LED_SRC_RESET = 8'b0001_1110;   // HW drives LEDs 1 to 4

   // An address hits a region when its masked bits equal the base
   typedef struct packed {
      logic [11:0] base;
      logic [11:0] mask;
   } apb_region_t;

   localparam apb_region_t SETTINGS_REGION = '{base: 12'h000, mask: 12'hc00};   // 0x000-0x3fc
   localparam apb_region_t READBACK_REGION = '{base: 12'h400, mask: 12'hfc0};   // 0x400-0x43c

endpackage

`default_nettype wire

// File: apb_decode.sv
////////////////////
// APB front end
// Turns APB writes into settings strobes and serves reads
// from the readback table with zero wait states
////////////////////
`timescale 1ns/1ps
`default_nettype none

module apb_decode
   import u2_types_pkg::*;
   import u2_regs_pkg::*;
(
   input  wire logic      dsp_clk,
   input  wire logic      por_rst,
   input  wire logic      psel_i,
   input  wire logic      penable_i,
   input  wire logic      pwrite_i,
   input  wire apb_addr_t paddr_i,
   input  wire word_t     pwdata_i,
   input  wire word_t     rb_data_i,
   output logic           pready_o,
   output word_t          prdata_o,
   output logic           pslverr_o,
   output set_bus_t       set_o,
   output rb_sel_t        rb_sel_o
);

   logic hit_set;
   logic hit_rb;
   logic access;
   logic wr_ok;
   logic rd_ok;

   ////////////////////
   // Region and direction
   assign hit_set = (paddr_i & SETTINGS_REGION.mask) == SETTINGS_REGION.base;
   assign hit_rb  = (paddr_i & READBACK_REGION.mask) == READBACK_REGION.base;
   assign access  = psel_i & penable_i;   // access phase
   assign wr_ok   = hit_set & pwrite_i;    // settings are write only
   assign rd_ok   = hit_rb & ~pwrite_i;    // readback is read only

   // Never stalls
   assign pready_o  = penable_i;
   assign pslverr_o = access & ~(wr_ok | rd_ok);

   // Word index and data for reads
   assign rb_sel_o = paddr_i[5:2];
   assign prdata_o = (access & rd_ok) ? rb_data_i : '0;

   ////////////////////
   // Settings strobe, one cycle after completion
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         set_o.stb <= 1'b0;
      end else begin
         set_o.stb <= access & wr_ok;
      end
      if (access & wr_ok) begin
         set_o.addr <= paddr_i[9:2];   // register number
         set_o.data <= pwdata_i;
      end
   end

   // Access phase only while the master selects us
   assert property (@(posedge dsp_clk) disable iff (por_rst) penable_i |-> psel_i)
      else $error("APB penable high without psel");

endmodule

`default_nettype wire

// File: misc_settings.sv
////////////////////
// Misc control registers
// Clock, SERDES, ADC, LED and PHY reset settings
////////////////////
`timescale 1ns/1ps
`default_nettype none

module misc_settings
   import u2_types_pkg::*;
   import u2_regs_pkg::*;
#(
   parameter int unsigned BASE = 0
) (
   input  wire logic      dsp_clk,
   input  wire logic      por_rst,
   input  wire set_bus_t  set_i,
   output logic [4:0]     clock_ctrl_o,
   output logic [3:0]     serdes_ctrl_o,
   output logic [3:0]     adc_ctrl_o,
   output logic [7:0]     led_sw_o,
   output logic [7:0]     led_src_o,
   output logic           phy_reset_n_o
);

   localparam set_addr_t A_CLOCK   = set_addr_t'(BASE + MISC_CLOCK);
   localparam set_addr_t A_SERDES  = set_addr_t'(BASE + MISC_SERDES);
   localparam set_addr_t A_ADC     = set_addr_t'(BASE + MISC_ADC);
   localparam set_addr_t A_LED_SW  = set_addr_t'(BASE + MISC_LED_SW);
   localparam set_addr_t A_PHY     = set_addr_t'(BASE + MISC_PHY);
   localparam set_addr_t A_LED_SRC = set_addr_t'(BASE + MISC_LED_SRC);

   logic phy_reset;   // stored active high

   ////////////////////
   // Register bank
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clock_ctrl_o  <= '0;
         serdes_ctrl_o <= '0;
         adc_ctrl_o    <= '0;
         led_sw_o      <= '0;
         led_src_o     <= LED_SRC_RESET;
         phy_reset     <= 1'b0;
      end else if (set_i.stb) begin
         case (set_i.addr)
            A_CLOCK:   clock_ctrl_o  <= set_i.data[4:0];   // ready, en[1:0], sel[1:0]
            A_SERDES:  serdes_ctrl_o <= set_i.data[3:0];   // enable, prbs, loop, rx_en
            A_ADC:     adc_ctrl_o    <= set_i.data[3:0];   // oe/on for A and B
            A_LED_SW:  led_sw_o      <= set_i.data[7:0];
            A_PHY:     phy_reset     <= set_i.data[0];
            A_LED_SRC: led_src_o     <= set_i.data[7:0];
            default: begin
            end
         endcase
      end
   end

   assign phy_reset_n_o = ~phy_reset;

   // Decode must never see a strobe with a floating address
   assert property (@(posedge dsp_clk) disable iff (por_rst)
                    set_i.stb |-> !$isunknown(set_i.addr))
      else $error("settings strobe with unknown address");

endmodule

`default_nettype wire

// File: vita_timer.sv
////////////////////
// VITA time counter
// Free running 64-bit tick count, loadable over the settings bus
////////////////////
`timescale 1ns/1ps
`default_nettype none

module vita_timer
   import u2_types_pkg::*;
   import u2_regs_pkg::*;
#(
   parameter int unsigned BASE = 10
) (
   input  wire logic      dsp_clk,
   input  wire logic      por_rst,
   input  wire set_bus_t  set_i,
   output vita_time_t     vita_time_o
);

   localparam set_addr_t A_HI = set_addr_t'(BASE + TIME_HI);
   localparam set_addr_t A_LO = set_addr_t'(BASE + TIME_LO);

   word_t hi_stage;   // waits for the low word
   logic  hi_wr;
   logic  load;

   assign hi_wr = set_i.stb & (set_i.addr == A_HI);
   assign load  = set_i.stb & (set_i.addr == A_LO);

   ////////////////////
   // High word staging
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         hi_stage <= '0;
      end else if (hi_wr) begin
         hi_stage <= set_i.data;
      end
   end

   // Counter, both halves land together
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time_o <= '0;
      end else if (load) begin
         vita_time_o <= {hi_stage, set_i.data};
      end else begin
         vita_time_o <= vita_time_o + 64'd1;
      end
   end

   // Time only moves by one tick unless a load is in progress
   assert property (@(posedge dsp_clk) disable iff (por_rst)
                    !load |=> vita_time_o == $past(vita_time_o) + 64'd1)
      else $error("VITA time skipped without a load");

endmodule

`default_nettype wire

// File: readback_mux.sv
////////////////////
// Readback table and LED mux
// Builds the status words and picks HW or SW per LED
////////////////////
`timescale 1ns/1ps
`default_nettype none

module readback_mux
   import u2_types_pkg::*;
   import u2_regs_pkg::*;
(
   input  wire rb_sel_t    rb_sel_i,
   input  wire vita_time_t vita_time_i,
   input  wire logic [7:0] led_sw_i,
   input  wire logic [7:0] led_src_i,
   input  wire logic       run_rx_i,
   input  wire logic       run_tx_i,
   input  wire logic       clk_status_i,
   input  wire logic       link_up_i,
   input  wire logic       good_sync_i,
   input  wire logic       spi_ready_i,
   input  wire logic       button_i,
   output word_t           rb_data_o,
   output logic [7:0]      leds_o
);

   word_t      status_w;
   logic [7:0] led_hw;

   assign status_w = {18'b0, button_i, spi_ready_i, clk_status_i, link_up_i, 10'b0};

   ////////////////////
   // LEDs, source bit 1 selects the HW pattern
   assign led_hw = {3'b0, run_tx_i, run_rx_i, clk_status_i, link_up_i & good_sync_i, 1'b0};
   assign leds_o = (led_src_i & led_hw) | (~led_src_i & led_sw_i);

   ////////////////////
   // Word table
   always_comb begin
      case (rb_sel_i)
         RB_SPI:     rb_data_o = RB_UNUSED;   // no SPI core here
         RB_TIME_HI: rb_data_o = vita_time_i[63:32];
         RB_TIME_LO: rb_data_o = vita_time_i[31:0];
         RB_COMPAT:  rb_data_o = COMPAT_NUM;
         RB_STATUS:  rb_data_o = status_w;
         default:    rb_data_o = RB_UNUSED;
      endcase
   end

endmodule

`default_nettype wire

// File: u2_ctrl_top.sv
////////////////////
// u2 control plane top
// APB decode, settings and timer, readback and LEDs
////////////////////
`timescale 1ns/1ps
`default_nettype none

module u2_ctrl_top
   import u2_types_pkg::*;
   import u2_regs_pkg::*;
(
   input  wire logic       dsp_clk,
   input  wire logic       por_rst,
   // APB slave
   input  wire logic       psel_i,
   input  wire logic       penable_i,
   input  wire logic       pwrite_i,
   input  wire apb_addr_t  paddr_i,
   input  wire word_t      pwdata_i,
   output logic            pready_o,
   output word_t           prdata_o,
   output logic            pslverr_o,
   // Status from the radio blocks
   input  wire logic       run_rx_i,
   input  wire logic       run_tx_i,
   input  wire logic       clk_status_i,
   input  wire logic       link_up_i,
   input  wire logic       good_sync_i,
   input  wire logic       spi_ready_i,
   input  wire logic       button_i,
   // Board controls
   output logic [7:0]      leds_o,
   output logic [4:0]      clock_ctrl_o,
   output logic [3:0]      serdes_ctrl_o,
   output logic [3:0]      adc_ctrl_o,
   output logic            phy_reset_n_o
);

   set_bus_t   set_bus;
   rb_sel_t    rb_sel;
   word_t      rb_data;
   vita_time_t vita_time;
   logic [7:0] led_sw;
   logic [7:0] led_src;

   ////////////////////
   // Decode
   apb_decode apb_decode_i (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
      .paddr_i(paddr_i), .pwdata_i(pwdata_i), .rb_data_i(rb_data),
      .pready_o(pready_o), .prdata_o(prdata_o), .pslverr_o(pslverr_o),
      .set_o(set_bus), .rb_sel_o(rb_sel)
   );

   ////////////////////
   // Execute
   misc_settings #(.BASE(SR_MISC)) misc_settings_i (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_i(set_bus),
      .clock_ctrl_o(clock_ctrl_o), .serdes_ctrl_o(serdes_ctrl_o), .adc_ctrl_o(adc_ctrl_o),
      .led_sw_o(led_sw), .led_src_o(led_src), .phy_reset_n_o(phy_reset_n_o)
   );

   vita_timer #(.BASE(SR_TIME64)) vita_timer_i (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_i(set_bus),
      .vita_time_o(vita_time)
   );

   ////////////////////
   // Result
   readback_mux readback_mux_i (
      .rb_sel_i(rb_sel), .vita_time_i(vita_time),
      .led_sw_i(led_sw), .led_src_i(led_src),
      .run_rx_i(run_rx_i), .run_tx_i(run_tx_i), .clk_status_i(clk_status_i),
      .link_up_i(link_up_i), .good_sync_i(good_sync_i),
      .spi_ready_i(spi_ready_i), .button_i(button_i),
      .rb_data_o(rb_data), .leds_o(leds_o)
   );

endmodule

`default_nettype wire

// File: tb_u2_ctrl.sv
////////////////////
// u2 control plane testbench
// Replays APB operations from the stimulus file and checks
// outputs and readback words against the expected columns
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_u2_ctrl;

   localparam int         TIMEOUT     = 50;             // cycles per wait
   localparam logic [7:0] LED_SRC_RST = 8'b0001_1110;

   logic        dsp_clk;
   logic        por_rst;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [11:0] paddr;
   logic [31:0] pwdata;
   logic        pready;
   logic [31:0] prdata;
   logic        pslverr;
   logic        run_rx;
   logic        run_tx;
   logic        clk_status;
   logic        link_up;
   logic        good_sync;
   logic        spi_ready;
   logic        button;
   logic [7:0]  leds;
   logic [4:0]  clock_ctrl;
   logic [3:0]  serdes_ctrl;
   logic [3:0]  adc_ctrl;
   logic        phy_reset_n;

   int           pass_count;
   int           fail_count;
   int           test_fails;
   int           test_num;
   logic [127:0] test_name;
   logic         run_error;    // timeout or bad file
   logic [31:0]  lcg_state;
   logic [7:0]   sw_m;         // last software LED value
   logic [7:0]   src_m;        // last LED source value
   logic [31:0]  prev_lo;

   u2_ctrl_top dut_i (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
      .paddr_i(paddr), .pwdata_i(pwdata),
      .pready_o(pready), .prdata_o(prdata), .pslverr_o(pslverr),
      .run_rx_i(run_rx), .run_tx_i(run_tx), .clk_status_i(clk_status),
      .link_up_i(link_up), .good_sync_i(good_sync),
      .spi_ready_i(spi_ready), .button_i(button),
      .leds_o(leds), .clock_ctrl_o(clock_ctrl), .serdes_ctrl_o(serdes_ctrl),
      .adc_ctrl_o(adc_ctrl), .phy_reset_n_o(phy_reset_n)
   );

   always #5 dsp_clk = ~dsp_clk;   // 100 MHz

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Source bit set picks the status pattern, clear picks software
   function automatic logic [7:0] led_expect(input logic [7:0] src, input logic [7:0] sw);
      logic [7:0] hw;
      hw    = 8'b0;
      hw[4] = run_tx;
      hw[3] = run_rx;
      hw[2] = clk_status;
      hw[1] = link_up & good_sync;
      return (src & hw) | (~src & sw);
   endfunction

   task automatic check_value(input logic ok, input string what,
                              input logic [31:0] got, input logic [31:0] want);
      if (ok) pass_count++;
      assert (ok) else begin
         $display("CHECK FAILED at time %0t: %s got %h expected %h", $time, what, got, want);
         fail_count++;
         test_fails++;
      end
   endtask

   ////////////////////
   // One APB transfer with its setup and access cycles
   task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                           output logic [31:0] rdata, output logic err);
      int waited;
      @(negedge dsp_clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = data;
      #1;
      // Setup cycle is no transfer yet
      check_value(!pready && !pslverr, "setup cycle pready and pslverr",
                  {30'b0, pready, pslverr}, 32'h0);
      @(negedge dsp_clk);
      penable = 1'b1;
      #1;
      waited = 0;
      while (!pready && waited < TIMEOUT) begin
         @(negedge dsp_clk);
         #1;
         waited++;
      end
      rdata = prdata;   // settled well before the rising edge
      err   = pslverr;
      if (!pready) begin
         $display("ERROR: DUT gave no pready within %0d cycles at address %h", TIMEOUT, addr);
         run_error = 1'b1;
      end
      check_value(waited == 0, "access wait states", waited, 32'h0);
      @(posedge dsp_clk);
      @(negedge dsp_clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic end_test();
      if (test_num != 0) begin
         $display("test %0d %0s: %s (%0d failed checks)", test_num, test_name,
                  (test_fails == 0) ? "ok" : "FAILED", test_fails);
      end
   endtask

   ////////////////////
   // Execute one line of the stimulus file
   task automatic run_op(input string line, input logic [63:0] op_s, input logic [31:0] addr_v,
                         input logic [127:0] data_s, input logic [63:0] exp_s,
                         input logic [31:0] err_v);
      logic [63:0]  op_d;
      logic [31:0]  addr_d;
      logic [127:0] data_d;
      logic [31:0]  data_v;
      logic [31:0]  exp_v;
      logic [31:0]  rdata;
      logic [31:0]  got;
      logic         err;
      int           n;
      data_v = '0;
      exp_v  = '0;
      got    = '0;
      if (data_s == "rand") begin
         lcg_state = lcg_next(lcg_state);
         data_v    = lcg_state;
      end else begin
         n = $sscanf(line, "%s %h %h", op_d, addr_d, data_v);
      end
      n = $sscanf(line, "%s %h %s %h", op_d, addr_d, data_d, exp_v);
      case (op_s)
         "test": begin
            end_test();
            test_num   = int'(addr_v);
            test_name  = data_s;
            test_fails = 0;
            prev_lo    = '0;
         end
         "status": begin
            run_rx     = data_v[0];
            run_tx     = data_v[1];
            clk_status = data_v[2];
            link_up    = data_v[3];
            good_sync  = data_v[4];
            spi_ready  = data_v[5];
            button     = data_v[6];
         end
         "write": begin
            apb_xfer(1'b1, addr_v[11:0], data_v, rdata, err);
            check_value(err == err_v[0], "write error flag", {31'b0, err}, err_v);
            if (!err_v[0] && addr_v == 32'h00c) sw_m = data_v[7:0];
            if (!err_v[0] && addr_v == 32'h018) src_m = data_v[7:0];
         end
         "read": begin
            apb_xfer(1'b0, addr_v[11:0], 32'h0, rdata, err);
            check_value(err == err_v[0], "read error flag", {31'b0, err}, err_v);
            if (!err_v[0]) check_value(rdata == exp_v, "read data", rdata, exp_v);
         end
         "rdgrow": begin
            apb_xfer(1'b0, addr_v[11:0], 32'h0, rdata, err);
            check_value(rdata > exp_v && rdata > prev_lo, "growing time", rdata, exp_v);
            prev_lo = rdata;
         end
         "expect": begin
            repeat (2) @(posedge dsp_clk);   // settings land by the second edge
            @(negedge dsp_clk);
            if (exp_s == "model") exp_v = {24'b0, led_expect(src_m, sw_m)};
            case (addr_v)
               32'd0:   got = {27'b0, clock_ctrl};
               32'd1:   got = {28'b0, serdes_ctrl};
               32'd2:   got = {28'b0, adc_ctrl};
               32'd3:   got = {24'b0, leds};
               default: got = {31'b0, phy_reset_n};
            endcase
            check_value(got == exp_v, "output value", got, exp_v);
         end
         default: begin
            $display("ERROR: unknown operation in the stimulus file");
            fail_count++;
         end
      endcase
   endtask

   initial begin
      int           fd;
      int           n;
      string        line;
      logic [63:0]  op_s;
      logic [31:0]  addr_v;
      logic [127:0] data_s;
      logic [63:0]  exp_s;
      logic [31:0]  err_v;
      dsp_clk    = 1'b0;
      por_rst    = 1'b1;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = '0;
      pwdata     = '0;
      run_rx     = 1'b0;
      run_tx     = 1'b0;
      clk_status = 1'b0;
      link_up    = 1'b0;
      good_sync  = 1'b0;
      spi_ready  = 1'b0;
      button     = 1'b0;
      pass_count = 0;
      fail_count = 0;
      test_fails = 0;
      test_num   = 0;
      test_name  = '0;
      run_error  = 1'b0;
      lcg_state  = 32'hd0e9_e8cd;
      sw_m       = 8'h00;
      src_m      = LED_SRC_RST;
      prev_lo    = '0;
      repeat (16) @(posedge dsp_clk);
      @(negedge dsp_clk);
      por_rst = 1'b0;
      fd = $fopen("u2_ctrl_stimulus.txt", "r");
      if (fd == 0) begin
         $display("ERROR: the stimulus file could not be opened");
         run_error = 1'b1;
      end else begin
         while (!$feof(fd) && !run_error) begin
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != 8'h23) begin   // skip # lines
               n = $sscanf(line, "%s %h %s %s %h", op_s, addr_v, data_s, exp_s, err_v);
               if (n == 5) run_op(line, op_s, addr_v, data_s, exp_s, err_v);
            end
         end
         $fclose(fd);
      end
      end_test();
      $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
      if (fail_count == 0 && !run_error) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: u2_ctrl_stimulus.txt
# columns: op addr data expect err ; op is test, status, write, read, rdgrow or expect
# status data bits 6..0 = button spi_ready good_sync link_up clk_status run_tx run_rx
test   1   after_reset  -         0
status 0   1f           -         0
expect 0   -            00        0
expect 1   -            0         0
expect 2   -            0         0
expect 4   -            1         0
expect 3   -            1e        0
test   2   led_mux      -         0
write  00c rand         -         0
write  018 5a           -         0
expect 3   -            model     0
status 0   0a           -         0
expect 3   -            model     0
write  018 00           -         0
expect 3   -            model     0
write  018 ff           -         0
expect 3   -            10        0
write  00c 000000a5     -         0
write  018 0f           -         0
expect 3   -            a0        0
test   3   ctrl_regs    -         0
write  000 ffffffe5     -         0
expect 0   -            05        0
write  004 0000003c     -         0
expect 1   -            c         0
write  008 0000000a     -         0
expect 2   -            a         0
write  010 00000001     -         0
expect 4   -            0         0
write  010 fffffffe     -         0
expect 4   -            1         0
write  000 0000001f     -         0
expect 0   -            1f        0
test   4   readback     -         0
read   430 0            000a0000  0
status 0   65           -         0
read   434 0            00003800  0
status 0   0f           -         0
read   434 0            00000c00  0
read   400 0            ffffffff  0
read   414 0            ffffffff  0
test   5   vita_time    -         0
write  028 12345678     -         0
write  02c 00000010     -         0
read   428 0            12345678  0
rdgrow 42c 0            00000010  0
rdgrow 42c 0            00000010  0
test   6   errors       -         0
read   000 0            00000000  1
write  430 ffffffff     -         1
read   440 0            00000000  1
write  500 ffffffff     -         1
expect 0   -            1f        0
expect 1   -            c         0
expect 2   -            a         0
expect 4   -            1         0
expect 3   -            ac        0
expect 3   -            model     0

// File: all.f
u2_types_pkg.sv
u2_regs_pkg.sv
apb_decode.sv
misc_settings.sv
vita_timer.sv
readback_mux.sv
u2_ctrl_top.sv
tb_u2_ctrl.sv

// File: run.sh
#!/bin/sh
# Build and run the u2 control plane testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_u2_ctrl \
   -o sim_u2_ctrl || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/sim_u2_ctrl)
echo "$out"
echo "$out" | grep -qx "Simulation passed" && echo "run.sh: OK" \
   || { echo "run.sh: testbench reported a failure"; exit 1; }
